// File: tti_tx_path.f
logic/tti_pkg.sv
logic/tx_bus_pkg.sv
logic/tti_queue.sv
logic/tx_word_to_byte.sv
logic/descriptor_tx.sv
logic/tti_tx_path.sv
testbench/tti_tx_path_assertions.sv
testbench/tti_tx_path_tb.sv

// File: Makefile
# Verilator build and run for the TTI transmit path testbench.

VERILATOR ?= verilator
TOP       ?= tti_tx_path_tb
FILELIST  ?= tti_tx_path.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the simulation passes only if the pass line shows up in its output.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tti_tx_path_tb.sv
// Testbench for the TTI transmit path with random descriptors, a byte model and abort cases.
`timescale 1ns/1ps

module tti_tx_path_tb;

  import tti_pkg::*;
  import tx_bus_pkg::*;

  localparam int unsigned Seed          = 39197;
  localparam int unsigned RstCycles     = 16;
  localparam int unsigned IdleCycles    = 20;
  localparam int unsigned NumDesc       = 8;              // descriptors per random test.
  localparam int unsigned MaxLen        = 64;             // 16 words, fits the data queue.
  localparam int unsigned DescCycles    = 4 * MaxLen + 64;
  localparam int unsigned TimeoutCycles = RstCycles + IdleCycles +
                                          (1 + 5 * NumDesc) * DescCycles + 500;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      desc_wvalid_i;
  tti_tx_desc_t              desc_wdata_i;
  logic                      desc_full_o;
  logic                      data_wvalid_i;
  logic [TtiTxDataWidth-1:0] data_wdata_i;
  logic                      data_full_o;
  logic                      tx_start_i;
  logic                      tx_abort_i;
  logic                      recovery_mode_enter_i;
  logic                      tx_desc_avail_o;
  tx_byte_t                  tx_byte_o;
  logic                      tx_byte_valid_o;
  logic                      tx_byte_ready_i;

  logic [8:0]  exp_q[$];                                  // {last, data} per expected byte.
  int unsigned desc_len[4*NumDesc];
  logic [31:0] desc_word[4*NumDesc][MaxLen/4];
  bit          backpressure;
  int unsigned seen_cnt;
  int unsigned cycle_cnt = 0;
  int unsigned error_cnt = 0;
  int unsigned test_cnt = 0;
  int unsigned failed_cnt = 0;
  int unsigned test_err_base;
  string       test_name;

  tti_tx_path tti_tx_path_inst (.*);

  bind descriptor_tx tti_tx_path_assertions assertions_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("run stopped after %0d cycles, the DUT did not finish the tests", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  always @(negedge clk_i) begin
    tx_byte_ready_i = backpressure ? ($urandom_range(3) != 0) : 1'b1; // ready low 1 in 4.
  end

  always @(posedge clk_i) begin
    if (rst_ni && tx_byte_valid_o && tx_byte_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("%s: byte %0h was sent when no byte was expected", test_name, tx_byte_o.data);
        error_cnt++;
      end else begin
        check_value("byte data", 32'(exp_q[0][7:0]), 32'(tx_byte_o.data));
        check_value("last flag", 32'(exp_q[0][8]), 32'(tx_byte_o.last));
        void'(exp_q.pop_front());
      end
      seen_cnt++;
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, expected, actual);
      error_cnt++;
    end
  endtask

  function automatic int unsigned total_errors();
    return error_cnt + tti_tx_path_inst.descriptor_tx_inst.assertions_inst.fail_cnt;
  endfunction

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = total_errors();
  endtask

  task automatic report_test();
    test_cnt++;
    if (total_errors() != test_err_base) begin
      failed_cnt++;
    end
    $display("test %0d %s: %s", test_cnt, test_name,
             (total_errors() == test_err_base) ? "passed" : "FAILED");
  endtask

  // writes one descriptor and its words, starts it and waits for the end or stops it early.
  task automatic send_descriptor(input int unsigned idx, input int unsigned stop_at,
                                 input bit recov);
    int unsigned len;
    int unsigned w;
    int unsigned b;
    len           = desc_len[idx];
    desc_wvalid_i = 1'b1;
    desc_wdata_i  = '{reserved: 16'($urandom), data_len: 16'(len)};
    @(negedge clk_i);
    desc_wvalid_i = 1'b0;
    check_value("desc avail after write", 32'd1, 32'(tx_desc_avail_o));
    for (w = 0; w < (len + 3) / 4; w++) begin
      data_wvalid_i = 1'b1;
      data_wdata_i  = desc_word[idx][w];
      @(negedge clk_i);
    end
    data_wvalid_i = 1'b0;
    for (b = 0; b < len; b++) begin
      exp_q.push_back({b == len - 1, 8'(desc_word[idx][b / 4] >> (8 * (b % 4)))});
    end
    seen_cnt   = 0;
    tx_start_i = 1'b1;
    while (tx_desc_avail_o) @(negedge clk_i);            // falls once the DUT accepts it.
    tx_start_i = 1'b0;
    if (stop_at != 0) begin
      while (seen_cnt < stop_at) @(negedge clk_i);
      tx_abort_i            = ~recov;
      recovery_mode_enter_i = recov;
      @(negedge clk_i);
      tx_abort_i            = 1'b0;
      recovery_mode_enter_i = 1'b0;
      exp_q.delete();                                     // rest is drained inside the DUT.
    end else begin
      while (exp_q.size() != 0) @(negedge clk_i);
    end
  endtask

  initial begin
    int unsigned i;
    int unsigned w;
    void'($urandom(Seed));
    rst_ni                = 1'b0;
    desc_wvalid_i         = 1'b0;
    desc_wdata_i          = '0;
    data_wvalid_i         = 1'b0;
    data_wdata_i          = '0;
    tx_start_i            = 1'b0;
    tx_abort_i            = 1'b0;
    recovery_mode_enter_i = 1'b0;
    tx_byte_ready_i       = 1'b1;
    backpressure          = 1'b0;
    for (i = 0; i < 4 * NumDesc; i++) begin
      case (i / NumDesc)
        0:       desc_len[i] = 4 * $urandom_range(MaxLen / 4, 1);
        1:       desc_len[i] = 4 * $urandom_range(MaxLen / 4 - 1, 0) + $urandom_range(3, 1);
        default: desc_len[i] = $urandom_range(MaxLen / 2, 8); // old and new words share the queue.
      endcase
      for (w = 0; w < MaxLen / 4; w++) begin
        desc_word[i][w] = $urandom;
      end
    end
    repeat (RstCycles) @(negedge clk_i);
    rst_ni = 1'b1;

    start_test("idle after reset");
    tx_start_i = 1'b1;                                    // no descriptor, must be ignored.
    repeat (IdleCycles) begin
      @(negedge clk_i);
      check_value("byte valid", 32'd0, 32'(tx_byte_valid_o));
      check_value("desc avail", 32'd0, 32'(tx_desc_avail_o));
      check_value("queue full", 32'd0, {30'd0, desc_full_o, data_full_o});
    end
    tx_start_i = 1'b0;
    report_test();

    start_test("desc avail handshake");
    send_descriptor(0, 0, 1'b0);
    report_test();

    start_test("word lengths, ready high");
    for (i = 0; i < NumDesc; i++) begin
      send_descriptor(i, 0, 1'b0);
    end
    report_test();

    start_test("word lengths, back-pressure");
    backpressure = 1'b1;
    for (i = 0; i < NumDesc; i++) begin
      send_descriptor(i, 0, 1'b0);
    end
    report_test();

    start_test("partial last word");
    for (i = NumDesc; i < 2 * NumDesc; i++) begin
      send_descriptor(i, 0, 1'b0);
    end
    report_test();

    start_test("abort and recovery");
    for (i = 2 * NumDesc; i < 4 * NumDesc; i += 2) begin
      send_descriptor(i, $urandom_range(desc_len[i] - 1, 1), 1'((i / 2) % 2));
      send_descriptor(i + 1, 0, 1'b0);
    end
    report_test();

    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, failed_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: testbench/tti_tx_path_assertions.sv
// Protocol checks on the descriptor block byte stream, descriptor pop and converter flush.
`timescale 1ns/1ps

module tti_tx_path_assertions (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 tti_tx_desc_queue_rvalid_i,
  input logic                 tti_tx_desc_queue_rready_o,
  input logic                 tx_queue_flush_o,
  input logic                 tx_abort_i,
  input logic                 recovery_mode_enter_i,
  input tx_bus_pkg::tx_byte_t tx_byte_o,
  input logic                 tx_byte_valid_o,
  input logic                 tx_byte_ready_i
);

  int unsigned fail_cnt = 0;   // failed assertion count.
  logic [2:0]  flush_wait_q;   // consecutive flush cycles without bus ready.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_wait_q <= '0;
    end else if (tx_queue_flush_o && !tx_byte_ready_i) begin
      flush_wait_q <= flush_wait_q + 3'd1;
    end else begin
      flush_wait_q <= '0;
    end
  end

  last_with_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_o.last |-> tx_byte_valid_o)
    else begin
      $error("last flag set without a valid byte");
      fail_cnt++;
    end

  // an abort or recovery entry may withdraw the byte.
  hold_while_stalled_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o && !tx_byte_ready_i && !tx_abort_i && !recovery_mode_enter_i
      |=> tx_byte_valid_o && $stable(tx_byte_o))
    else begin
      $error("byte or valid changed while ready was low");
      fail_cnt++;
    end

  // a new descriptor is taken only while no byte is presented.
  pop_with_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tti_tx_desc_queue_rready_o |-> tti_tx_desc_queue_rvalid_i && !tx_byte_valid_o)
    else begin
      $error("descriptor popped from an empty queue or during a transfer");
      fail_cnt++;
    end

  flush_bounded_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_wait_q <= 3'd4)
    else begin
      $error("flush held for more than 4 cycles without ready");
      fail_cnt++;
    end

endmodule

// File: logic/tti_tx_path.sv
// Transmit path of the TTI joining descriptor queue, data queue, converter and descriptor logic.
`timescale 1ns/1ps

module tti_tx_path (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // software writes.
  input  logic                               desc_wvalid_i,
  input  tti_pkg::tti_tx_desc_t              desc_wdata_i,
  output logic                               desc_full_o,
  input  logic                               data_wvalid_i,
  input  logic [tti_pkg::TtiTxDataWidth-1:0] data_wdata_i,
  output logic                               data_full_o,
  // bus FSM side.
  input  logic                               tx_start_i,
  input  logic                               tx_abort_i,
  input  logic                               recovery_mode_enter_i,
  output logic                               tx_desc_avail_o,
  output tx_bus_pkg::tx_byte_t               tx_byte_o,
  output logic                               tx_byte_valid_o,
  input  logic                               tx_byte_ready_i
);

  import tti_pkg::*;
  import tx_bus_pkg::*;

  tti_tx_desc_t               desc_rdata;
  logic                       desc_rvalid;
  logic                       desc_rready;
  logic [TtiTxDataWidth-1:0]  word_rdata;
  logic                       word_rvalid;
  logic                       word_rready;
  logic [TtiTxDepthWidth-1:0] data_depth;
  logic [TxByteWidth-1:0]     conv_byte;
  logic                       conv_byte_valid;
  logic                       conv_byte_ready;
  logic                       conv_flush;

  tti_queue #(
    .T     (tti_tx_desc_t),
    .Depth (TtiTxDescDepth)
  ) desc_queue_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (desc_wvalid_i),
    .wdata_i  (desc_wdata_i),
    .full_o   (desc_full_o),
    .rvalid_o (desc_rvalid),
    .rready_i (desc_rready),
    .rdata_o  (desc_rdata),
    .depth_o  (),
    .flush_i  (1'b0)
  );

  tti_queue #(
    .T     (logic [TtiTxDataWidth-1:0]),
    .Depth (TtiTxDataDepth)
  ) data_queue_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (data_wvalid_i),
    .wdata_i  (data_wdata_i),
    .full_o   (data_full_o),
    .rvalid_o (word_rvalid),
    .rready_i (word_rready),
    .rdata_o  (word_rdata),
    .depth_o  (data_depth),
    .flush_i  (1'b0)          // only the converter's held word is flushed.
  );

  tx_word_to_byte tx_word_to_byte_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (word_rvalid),
    .word_ready_o (word_rready),
    .word_i       (word_rdata),
    .byte_valid_o (conv_byte_valid),
    .byte_ready_i (conv_byte_ready),
    .byte_o       (conv_byte),
    .flush_i      (conv_flush)
  );

  descriptor_tx descriptor_tx_inst (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .tti_tx_desc_queue_rvalid_i (desc_rvalid),
    .tti_tx_desc_queue_rready_o (desc_rready),
    .tti_tx_desc_queue_rdata_i  (desc_rdata),
    .tti_tx_queue_rvalid_i      (conv_byte_valid),
    .tti_tx_queue_depth_i       (data_depth),
    .tti_tx_queue_rready_o      (conv_byte_ready),
    .tti_tx_queue_rdata_i       (conv_byte),
    .tx_queue_flush_o           (conv_flush),
    .tx_start_i                 (tx_start_i),
    .tx_abort_i                 (tx_abort_i),
    .recovery_mode_enter_i      (recovery_mode_enter_i),
    .tx_desc_avail_o            (tx_desc_avail_o),
    .tx_byte_o                  (tx_byte_o),
    .tx_byte_valid_o            (tx_byte_valid_o),
    .tx_byte_ready_i            (tx_byte_ready_i)
  );

endmodule

// File: logic/descriptor_tx.sv
// TX descriptor handling with start rule, byte counting, last marking and abort draining.
`timescale 1ns/1ps

module descriptor_tx (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // descriptor queue read side.
  input  logic                                tti_tx_desc_queue_rvalid_i,
  output logic                                tti_tx_desc_queue_rready_o,
  input  tti_pkg::tti_tx_desc_t               tti_tx_desc_queue_rdata_i,
  // byte stream from the word converter.
  input  logic                                tti_tx_queue_rvalid_i,
  input  logic [tti_pkg::TtiTxDepthWidth-1:0] tti_tx_queue_depth_i,
  output logic                                tti_tx_queue_rready_o,
  input  logic [tx_bus_pkg::TxByteWidth-1:0]  tti_tx_queue_rdata_i,
  output logic                                tx_queue_flush_o,
  // bus FSM side.
  input  logic                                tx_start_i,
  input  logic                                tx_abort_i,
  input  logic                                recovery_mode_enter_i,
  output logic                                tx_desc_avail_o,
  output tx_bus_pkg::tx_byte_t                tx_byte_o,
  output logic                                tx_byte_valid_o,
  input  logic                                tx_byte_ready_i
);

  import tti_pkg::*;

  tti_tx_desc_t             desc_q;
  logic                     desc_valid_q;
  logic                     pending_q;
  logic                     drain_q;
  logic [TtiTxLenWidth-1:0] byte_cnt_q;
  logic [TtiTxDepthWidth:0] words_avail;
  logic [TtiTxDepthWidth:0] words_needed;
  logic                     stop_req;
  logic                     tx_start;
  logic                     byte_take;
  logic                     cnt_last;
  logic                     end_normal;
  logic                     drain_start;
  logic                     drain_end;

  assign stop_req = tx_abort_i | recovery_mode_enter_i;

  assign tx_desc_avail_o = tti_tx_desc_queue_rvalid_i;

  // one descriptor at a time, and never while the previous one is drained.
  assign tti_tx_desc_queue_rready_o = tx_start_i & tti_tx_desc_queue_rvalid_i &
                                      ~desc_valid_q & ~drain_q & ~stop_req;

  // Start rule uses the length in whole words, rounded down.
  // The converter may already hold one word, hence the extra one.
  assign words_avail  = {1'b0, tti_tx_queue_depth_i} + 1'b1;
  assign words_needed = (TtiTxDepthWidth + 1)'(desc_q.data_len >> 2);
  assign tx_start     = desc_valid_q & ~pending_q & ~drain_q & ~stop_req &
                        (words_avail >= words_needed);

  assign cnt_last   = byte_cnt_q == TtiTxLenWidth'(1);
  assign byte_take  = tx_byte_valid_o & tx_byte_ready_i;
  assign end_normal = byte_take & cnt_last;

  // a byte accepted in the abort cycle still counts as sent.
  assign drain_start = stop_req & desc_valid_q & ~drain_q & ~end_normal;
  assign drain_end   = drain_q & tti_tx_queue_rvalid_i & cnt_last;

  assign tx_byte_valid_o = pending_q & tti_tx_queue_rvalid_i;
  assign tx_byte_o.data  = tti_tx_queue_rdata_i;
  assign tx_byte_o.last  = tx_byte_valid_o & cnt_last;

  assign tti_tx_queue_rready_o = byte_take | (drain_q & tti_tx_queue_rvalid_i);

  // partial last word is dropped so the next descriptor starts on byte 0.
  assign tx_queue_flush_o = drain_end | (end_normal & (|desc_q.data_len[1:0]));

  always_ff @(posedge clk_i) begin
    if (tti_tx_desc_queue_rready_o) begin
      desc_q <= tti_tx_desc_queue_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_valid_q <= 1'b0;
    end else if (tti_tx_desc_queue_rready_o) begin
      desc_valid_q <= 1'b1;
    end else if (end_normal | drain_end) begin
      desc_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (tx_start) begin
      pending_q <= 1'b1;
    end else if (end_normal | drain_start) begin
      pending_q <= 1'b0;               // stop presenting bytes at once.
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      drain_q <= 1'b0;
    end else if (drain_start) begin
      drain_q <= 1'b1;
    end else if (drain_end) begin
      drain_q <= 1'b0;
    end
  end

  // Counts the bytes still owed by the current descriptor.
  // An abort before the first byte loads the full length so that all of
  // the descriptor's data is drained. A zero length is not expected.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
    end else if (tx_start | (drain_start & ~pending_q)) begin
      byte_cnt_q <= desc_q.data_len;
    end else if (tti_tx_queue_rready_o) begin
      byte_cnt_q <= byte_cnt_q - 1'b1;
    end
  end

endmodule

// File: logic/tx_word_to_byte.sv
// Splits 32-bit data words into a byte stream, least significant byte first.
`timescale 1ns/1ps

module tx_word_to_byte (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               word_valid_i,
  output logic                               word_ready_o,
  input  logic [tti_pkg::TtiTxDataWidth-1:0] word_i,
  output logic                               byte_valid_o,
  input  logic                               byte_ready_i,
  output logic [tx_bus_pkg::TxByteWidth-1:0] byte_o,
  input  logic                               flush_i
);

  import tti_pkg::*;
  import tx_bus_pkg::*;

  logic [TtiTxDataWidth-1:0] word_q;
  logic                      held_q;
  logic [1:0]                idx_q;
  logic                      take;
  logic                      last_taken;

  assign byte_valid_o = held_q;
  assign byte_o       = word_q[idx_q*TxByteWidth +: TxByteWidth];

  assign take       = byte_valid_o & byte_ready_i;
  assign last_taken = take & (idx_q == 2'd3);

  // Fetch a word when empty or when the top byte leaves.
  // A flush holds off the fetch for one cycle so the held word is simply dropped.
  assign word_ready_o = (~held_q | last_taken) & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (word_valid_i & word_ready_o) begin
      word_q <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
      idx_q  <= '0;
    end else if (flush_i) begin
      held_q <= 1'b0;                  // rest of the word is discarded.
      idx_q  <= '0;
    end else if (word_ready_o) begin
      held_q <= word_valid_i;
      idx_q  <= '0;
    end else if (take) begin
      idx_q <= idx_q + 1'b1;
    end
  end

endmodule

// File: logic/tti_queue.sv
// Synchronous FIFO with a typed payload, an occupancy output and a full flush.
`timescale 1ns/1ps

module tti_queue #(
  parameter type         T     = logic [31:0],
  parameter int unsigned Depth = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                wvalid_i,
  input  T                                    wdata_i,
  output logic                                full_o,
  output logic                                rvalid_o,
  input  logic                                rready_i,
  output T                                    rdata_o,
  output logic [tti_pkg::TtiTxDepthWidth-1:0] depth_o,
  input  logic                                flush_i
);

  import tti_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  T                    mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  assign full_o   = count_q == CntWidth'(Depth);
  assign rvalid_o = count_q != '0;
  assign rdata_o  = mem_q[rd_ptr_q];           // head entry, straight from storage.
  assign depth_o  = TtiTxDepthWidth'(count_q);

  assign push = wvalid_i & ~full_o & ~flush_i; // writes to a full queue are dropped.
  assign pop  = rvalid_o & rready_i & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr_q == PtrWidth'(Depth - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_q == PtrWidth'(Depth - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // idle, or push and pop together.
      endcase
    end
  end

endmodule

// File: logic/tx_bus_pkg.sv
// Byte stream format handed from the TTI transmit path to the bus FSM.
package tx_bus_pkg;

  // width of one bus data byte.
  localparam int unsigned TxByteWidth = 8;

  // One byte of a private read.
  // last marks the final byte of a descriptor, so the bus FSM can
  // finish the transfer with the right end indication.
  typedef struct packed {
    logic [TxByteWidth-1:0] data;  // byte value.
    logic                   last;  // final byte of the descriptor.
  } tx_byte_t;

endpackage

// File: logic/tti_pkg.sv
// TTI queue sizes and the TX descriptor format shared by the queue and descriptor logic.
package tti_pkg;

  // width of one data word written by software.
  localparam int unsigned TtiTxDataWidth = 32;

  // number of descriptors the descriptor queue can hold.
  localparam int unsigned TtiTxDescDepth = 4;

  // number of data words the data queue can hold.
  localparam int unsigned TtiTxDataDepth = 16;

  // width of the occupancy count reported by a queue.
  localparam int unsigned TtiTxDepthWidth = 16;

  // width of the byte length field in a descriptor.
  localparam int unsigned TtiTxLenWidth = 16;

  // TX descriptor as written by software.
  // Only the length is interpreted by the hardware, the upper half is kept
  // for future flags and is carried along untouched.
  typedef struct packed {
    logic [15:0]              reserved;  // not interpreted.
    logic [TtiTxLenWidth-1:0] data_len;  // payload length in bytes.
  } tti_tx_desc_t;

endpackage
